//--- controlUnit.f
+incdir+verification
hw/controlPkg.sv
hw/instructionDecoder.sv
hw/stateSequencer.sv
hw/controlWordGenerator.sv
hw/controlUnit.sv
verification/controlUnitTb.sv

//--- hw/controlPkg.sv
`default_nettype none

package controlPkg;

    // Machine states
    typedef enum logic [5:0] {
        stateFetch = 6'b000000,
        stateAdd   = 6'b000001,
        stateMult  = 6'b000100,
        stateMfhi  = 6'b000110,
        stateMflo  = 6'b000111,
        stateAddi  = 6'b010010,
        stateBeq   = 6'b010100,
        stateBne   = 6'b010101,
        stateBle   = 6'b010110,
        stateBgt   = 6'b010111,
        stateReset = 6'b111111
    } stateT;

    typedef logic [2:0] stepT;

    typedef logic [5:0] opcodeT;
    typedef logic [5:0] functT;

    // Opcodes
    localparam opcodeT opR     = 6'b000000;
    localparam opcodeT opAddi  = 6'b001000;
    localparam opcodeT opBeq   = 6'b000100;
    localparam opcodeT opBne   = 6'b000101;
    localparam opcodeT opBle   = 6'b000110;
    localparam opcodeT opBgt   = 6'b000111;
    localparam opcodeT opReset = 6'b111111;

    // R-type funct field
    localparam functT functAdd  = 6'b100000;
    localparam functT functMult = 6'b011000;
    localparam functT functMfhi = 6'b010000;
    localparam functT functMflo = 6'b010010;

    // Codes understood by the ALU control block
    typedef enum logic [5:0] {
        aluOpCompare = 6'b000111,
        aluOpAdd     = 6'b100000
    } aluOpT;

    typedef enum logic [1:0] {
        aluSrcBReg  = 2'b00,
        aluSrcBFour = 2'b01,
        aluSrcBImm  = 2'b10
    } aluSrcBT;

    typedef enum logic [1:0] {
        regDstRt = 2'b00,
        regDstRd = 2'b01
    } regDstT;

    typedef enum logic [2:0] {
        memToRegAluOut = 3'b000,
        memToRegLo     = 3'b010,
        memToRegHi     = 3'b011
    } memToRegT;

    // Which compare results let a branch be taken
    typedef struct packed {
        logic eq;
        logic gt;
        logic lt;
    } branchFlagsT;

    typedef struct packed {
        logic        pcWrite;
        logic        pcWriteCond;
        logic        irWrite;
        logic        abWrite;
        logic        regWrite;
        logic        aluOutWrite;
        logic        hiloWrite;
        logic        useMult;
        logic        aluSrcA;
        aluSrcBT     aluSrcB;
        regDstT      regDst;
        memToRegT    memToReg;
        aluOpT       aluOp;
        branchFlagsT branchFlags;
    } controlWordT;

    // All writes off, all selects at zero
    localparam controlWordT controlIdle = '0;

    // Decode is the last fetch step
    localparam stepT fetchLastStep = 3'd5;

    // Final step index of the fixed-length execute sequences
    localparam stepT addLastStep  = 3'd2;
    localparam stepT addiLastStep = 3'd4;

endpackage

`default_nettype wire

//--- hw/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
    input  logic                    clock,
    input  logic                    reset,
    input  controlPkg::opcodeT      opcode,
    input  controlPkg::functT       funct,
    input  logic                    multDone,
    output controlPkg::controlWordT control,
    output logic                    resetOut
);

    controlPkg::stateT nextExecState;
    controlPkg::stateT state;
    controlPkg::stepT  step;

    instructionDecoder decoder (
        .opcode        (opcode),
        .funct         (funct),
        .nextExecState (nextExecState)
    );

    stateSequencer sequencer (
        .clock         (clock),
        .reset         (reset),
        .nextExecState (nextExecState),
        .multDone      (multDone),
        .state         (state),
        .step          (step)
    );

    // Registered outputs come from here
    controlWordGenerator generator (
        .clock    (clock),
        .reset    (reset),
        .state    (state),
        .step     (step),
        .multDone (multDone),
        .control  (control),
        .resetOut (resetOut)
    );

endmodule

`default_nettype wire

//--- hw/controlWordGenerator.sv
`timescale 1ns/1ps
`default_nettype none

module controlWordGenerator (
    input  logic                    clock,
    input  logic                    reset,
    input  controlPkg::stateT       state,
    input  controlPkg::stepT        step,
    input  logic                    multDone,
    output controlPkg::controlWordT control,
    output logic                    resetOut
);

    controlPkg::controlWordT nextControl;
    logic                    nextResetOut;

    // Reset level seen at the previous edge
    logic resetSeen;

    // Compare results that take each branch
    function automatic controlPkg::branchFlagsT flagsFor(input controlPkg::stateT branchState);
        controlPkg::branchFlagsT flags;
        flags = '0;
        case (branchState)
            controlPkg::stateBeq: begin
                flags.eq = 1'b1;
            end
            controlPkg::stateBne: begin
                flags.gt = 1'b1;
                flags.lt = 1'b1;
            end
            controlPkg::stateBle: begin
                flags.eq = 1'b1;
                flags.lt = 1'b1;
            end
            controlPkg::stateBgt: begin
                flags.gt = 1'b1;
            end
            default: ;
        endcase
        return flags;
    endfunction

    always_comb begin
        nextControl  = controlPkg::controlIdle;
        nextResetOut = 1'b0;

        case (state)
            controlPkg::stateFetch: begin
                nextControl.aluOp = controlPkg::aluOpAdd;
                if (step <= 3'd3) begin
                    // PC + 4 while the instruction is read
                    nextControl.aluSrcB = controlPkg::aluSrcBFour;
                end
                if (step == 3'd3) begin
                    nextControl.pcWrite = 1'b1;
                    nextControl.irWrite = 1'b1;
                end
                if (step == 3'd4) begin
                    nextControl.abWrite = 1'b1;
                    nextControl.aluSrcB = controlPkg::aluSrcBReg;
                end
            end

            controlPkg::stateAdd: begin
                nextControl.regWrite    = 1'b1;
                nextControl.aluSrcA     = 1'b1;
                nextControl.regDst      = controlPkg::regDstRd;
                nextControl.aluOp       = controlPkg::aluOpAdd;
                nextControl.aluOutWrite = (step != 3'd0);
            end

            controlPkg::stateAddi: begin
                nextControl.aluOutWrite = 1'b1;
                nextControl.aluSrcA     = 1'b1;
                nextControl.aluSrcB     = controlPkg::aluSrcBImm;
                nextControl.aluOp       = controlPkg::aluOpAdd;
                nextControl.regWrite    = (step != 3'd0);
            end

            controlPkg::stateBeq,
            controlPkg::stateBne,
            controlPkg::stateBle,
            controlPkg::stateBgt: begin
                nextControl.pcWriteCond = 1'b1;
                nextControl.aluSrcA     = 1'b1;
                nextControl.aluOp       = controlPkg::aluOpCompare;
                nextControl.branchFlags = flagsFor(state);
            end

            controlPkg::stateMfhi: begin
                nextControl.regWrite = 1'b1;
                nextControl.regDst   = controlPkg::regDstRd;
                nextControl.memToReg = controlPkg::memToRegHi;
            end

            controlPkg::stateMflo: begin
                nextControl.regWrite = 1'b1;
                nextControl.regDst   = controlPkg::regDstRd;
                nextControl.memToReg = controlPkg::memToRegLo;
            end

            controlPkg::stateMult: begin
                // Hold the request until done, then latch HI/LO once
                if (multDone) begin
                    nextControl.hiloWrite = 1'b1;
                end else begin
                    nextControl.useMult = 1'b1;
                end
            end

            controlPkg::stateReset: begin
                nextResetOut = 1'b1;
            end

            default: ;
        endcase
    end

    always_ff @(posedge clock) begin
        resetSeen <= reset;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            control  <= controlPkg::controlIdle;
            // Pulse on the first reset edge only
            resetOut <= !resetSeen;
        end else begin
            control  <= nextControl;
            resetOut <= nextResetOut;
        end
    end

endmodule

`default_nettype wire

//--- hw/instructionDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instructionDecoder (
    input  controlPkg::opcodeT opcode,
    input  controlPkg::functT  funct,
    output controlPkg::stateT  nextExecState
);

    always_comb begin
        // Unknown codes go straight back to fetch
        nextExecState = controlPkg::stateFetch;

        case (opcode)
            controlPkg::opR: begin
                case (funct)
                    controlPkg::functAdd: begin
                        nextExecState = controlPkg::stateAdd;
                    end
                    controlPkg::functMult: begin
                        nextExecState = controlPkg::stateMult;
                    end
                    controlPkg::functMfhi: begin
                        nextExecState = controlPkg::stateMfhi;
                    end
                    controlPkg::functMflo: begin
                        nextExecState = controlPkg::stateMflo;
                    end
                    default: ;
                endcase
            end
            controlPkg::opAddi: begin
                nextExecState = controlPkg::stateAddi;
            end
            controlPkg::opBeq: begin
                nextExecState = controlPkg::stateBeq;
            end
            controlPkg::opBne: begin
                nextExecState = controlPkg::stateBne;
            end
            controlPkg::opBle: begin
                nextExecState = controlPkg::stateBle;
            end
            controlPkg::opBgt: begin
                nextExecState = controlPkg::stateBgt;
            end
            // Trap into the reset state
            controlPkg::opReset: begin
                nextExecState = controlPkg::stateReset;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/stateSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module stateSequencer (
    input  logic              clock,
    input  logic              reset,
    input  controlPkg::stateT nextExecState,
    input  logic              multDone,
    output controlPkg::stateT state,
    output controlPkg::stepT  step
);

    controlPkg::stateT nextState;
    controlPkg::stepT  nextStep;

    // Reset level seen at the previous edge
    logic resetSeen;

    always_comb begin
        nextState = state;
        nextStep  = step + 3'd1;

        case (state)
            controlPkg::stateFetch: begin
                if (step == controlPkg::fetchLastStep) begin
                    // Decode picks the execute sequence
                    nextState = nextExecState;
                    nextStep  = '0;
                end
            end

            controlPkg::stateAdd: begin
                if (step == controlPkg::addLastStep) begin
                    nextState = controlPkg::stateFetch;
                    nextStep  = '0;
                end
            end

            controlPkg::stateAddi: begin
                if (step == controlPkg::addiLastStep) begin
                    nextState = controlPkg::stateFetch;
                    nextStep  = '0;
                end
            end

            // Single-step sequences
            controlPkg::stateBeq,
            controlPkg::stateBne,
            controlPkg::stateBle,
            controlPkg::stateBgt,
            controlPkg::stateMfhi,
            controlPkg::stateMflo: begin
                nextState = controlPkg::stateFetch;
                nextStep  = '0;
            end

            controlPkg::stateMult: begin
                // Wait here until the multiplier reports done
                nextStep = '0;
                if (multDone) begin
                    nextState = controlPkg::stateFetch;
                end
            end

            controlPkg::stateReset: begin
                // Trapped until external reset
                nextStep = '0;
            end

            default: begin
                nextState = controlPkg::stateFetch;
                nextStep  = '0;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        resetSeen <= reset;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            step <= '0;
            // Only the first reset edge enters the reset state
            if (resetSeen) begin
                state <= controlPkg::stateFetch;
            end else begin
                state <= controlPkg::stateReset;
            end
        end else begin
            state <= nextState;
            step  <= nextStep;
        end
    end

endmodule

`default_nettype wire

//--- verification/controlUnitTests.svh
// Opcode and funct that no sequence decodes
localparam controlPkg::opcodeT unknownOp    = 6'b110011;
localparam controlPkg::functT  unknownFunct = 6'b000001;

task automatic applyReset();
    reset = 1'b1;
    for (int idx = 1; idx <= resetCycles; idx++) begin
        waitEdge();
        // Only the first reset edge signals reset
        expectOutputs(seqIdle, idx, idx == 1);
    end
    reset = 1'b0;
endtask

task automatic runFetch(input controlPkg::opcodeT op, input controlPkg::functT fn);
    for (int idx = 1; idx <= 6; idx++) begin
        if (idx < 5) begin
            // Fields only need to be stable for the last two edges
            opcode = 6'($urandom);
            funct  = 6'($urandom);
        end else if (idx == 5) begin
            opcode = op;
            funct  = fn;
        end
        waitEdge();
        expectOutputs(seqFetch, idx, 1'b0);
    end
endtask

task automatic runExecute(input int seq, input int count);
    for (int idx = 1; idx <= count; idx++) begin
        waitEdge();
        expectOutputs(seq, idx, 1'b0);
    end
endtask

// Fetch, execute, then a full fetch to confirm the restart
task automatic runInstruction(input controlPkg::opcodeT op, input controlPkg::functT fn,
                              input int seq, input int count);
    runFetch(op, fn);
    runExecute(seq, count);
    runFetch(unknownOp, unknownFunct);
endtask

task automatic resetSequence();
    int errorsBefore;
    errorsBefore = errorCount;
    // One idle edge so the DUT has seen reset low before it rises
    waitEdge();
    applyReset();
    runFetch(unknownOp, unknownFunct);
    finishTest("reset sequence", errorsBefore);
endtask

task automatic arithmetic();
    int errorsBefore;
    errorsBefore = errorCount;
    runInstruction(controlPkg::opR, controlPkg::functAdd, seqAdd, 3);
    runInstruction(controlPkg::opAddi, 6'($urandom), seqAddi, 5);
    finishTest("add and addi", errorsBefore);
endtask

task automatic branchesAndMoves();
    int errorsBefore;
    errorsBefore = errorCount;
    runInstruction(controlPkg::opBeq, 6'($urandom), seqBeq, 1);
    runInstruction(controlPkg::opBne, 6'($urandom), seqBne, 1);
    runInstruction(controlPkg::opBle, 6'($urandom), seqBle, 1);
    runInstruction(controlPkg::opBgt, 6'($urandom), seqBgt, 1);
    runInstruction(controlPkg::opR, controlPkg::functMfhi, seqMfhi, 1);
    runInstruction(controlPkg::opR, controlPkg::functMflo, seqMflo, 1);
    finishTest("branches, mfhi and mflo", errorsBefore);
endtask

task automatic multiply();
    int errorsBefore;
    int delay;
    errorsBefore = errorCount;
    for (int run = 0; run < 4; run++) begin
        delay = 1 + ($urandom % 10);
        runFetch(controlPkg::opR, controlPkg::functMult);
        multDone = 1'b0;
        runExecute(seqMultWait, delay);
        // One-cycle done pulse from the multiplier
        multDone = 1'b1;
        waitEdge();
        expectOutputs(seqMultDone, 1, 1'b0);
        multDone = 1'b0;
        runFetch(unknownOp, unknownFunct);
    end
    finishTest("mult handshake", errorsBefore);
endtask

task automatic unknownCodes();
    int errorsBefore;
    errorsBefore = errorCount;
    runFetch(unknownOp, 6'($urandom));
    runFetch(controlPkg::opR, unknownFunct);
    runFetch(unknownOp, unknownFunct);
    finishTest("unknown opcode and funct", errorsBefore);
endtask

task automatic resetTrap();
    int errorsBefore;
    errorsBefore = errorCount;
    runFetch(controlPkg::opReset, 6'($urandom));
    for (int idx = 1; idx <= 5; idx++) begin
        waitEdge();
        expectOutputs(seqIdle, idx, 1'b1);
    end
    applyReset();
    runFetch(unknownOp, unknownFunct);
    finishTest("reset opcode", errorsBefore);
endtask

//--- verification/controlUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnitTb;

    localparam int clockPeriod = 20;
    localparam int resetCycles = 8;

    // Cycle budget of each test in run order
    localparam int budgetCycles = 15 + 32 + 78 + 92 + 18 + 25;

    // Execute sequences known to the expected-word table
    localparam int seqFetch    = 0;
    localparam int seqAdd      = 1;
    localparam int seqAddi     = 2;
    localparam int seqBeq      = 3;
    localparam int seqBne      = 4;
    localparam int seqBle      = 5;
    localparam int seqBgt      = 6;
    localparam int seqMfhi     = 7;
    localparam int seqMflo     = 8;
    localparam int seqMultWait = 9;
    localparam int seqMultDone = 10;
    localparam int seqIdle     = 11;

    logic                    clock = 1'b0;
    logic                    reset;
    controlPkg::opcodeT      opcode;
    controlPkg::functT       funct;
    logic                    multDone;
    controlPkg::controlWordT control;
    logic                    resetOut;

    int errorCount  = 0;
    int checkCount  = 0;
    int testCount   = 0;
    int failedTests = 0;
    int seedResult;

    always #(clockPeriod / 2) clock = ~clock;

    controlUnit DUT (
        .clock    (clock),
        .reset    (reset),
        .opcode   (opcode),
        .funct    (funct),
        .multDone (multDone),
        .control  (control),
        .resetOut (resetOut)
    );

    // Control word expected on a given edge of a sequence
    function automatic controlPkg::controlWordT expectedWord(input int seq, input int idx);
        controlPkg::controlWordT word;
        word = '0;
        case (seq)
            seqFetch: begin
                word.aluOp = controlPkg::aluOpAdd;
                if (idx <= 4) word.aluSrcB = controlPkg::aluSrcBFour;
                if (idx == 4) begin
                    word.pcWrite = 1'b1;
                    word.irWrite = 1'b1;
                end
                if (idx == 5) word.abWrite = 1'b1;
            end
            seqAdd: begin
                word.regWrite    = 1'b1;
                word.aluSrcA     = 1'b1;
                word.regDst      = controlPkg::regDstRd;
                word.aluOp       = controlPkg::aluOpAdd;
                word.aluOutWrite = (idx >= 2);
            end
            seqAddi: begin
                word.aluOutWrite = 1'b1;
                word.aluSrcA     = 1'b1;
                word.aluSrcB     = controlPkg::aluSrcBImm;
                word.aluOp       = controlPkg::aluOpAdd;
                word.regWrite    = (idx >= 2);
            end
            seqBeq, seqBne, seqBle, seqBgt: begin
                word.pcWriteCond = 1'b1;
                word.aluSrcA     = 1'b1;
                word.aluOp       = controlPkg::aluOpCompare;
                // Flags in eq, gt, lt order
                case (seq)
                    seqBeq:  word.branchFlags = 3'b100;
                    seqBne:  word.branchFlags = 3'b011;
                    seqBle:  word.branchFlags = 3'b101;
                    default: word.branchFlags = 3'b010;
                endcase
            end
            seqMfhi, seqMflo: begin
                word.regWrite = 1'b1;
                word.regDst   = controlPkg::regDstRd;
                if (seq == seqMfhi) word.memToReg = controlPkg::memToRegHi;
                else word.memToReg = controlPkg::memToRegLo;
            end
            seqMultWait: word.useMult = 1'b1;
            seqMultDone: word.hiloWrite = 1'b1;
            default: ;
        endcase
        return word;
    endfunction

    task automatic compareValue(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("FAIL time %0t %s: got %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic expectOutputs(input int seq, input int idx, input logic expectedResetOut);
        compareValue("control", control, expectedWord(seq, idx));
        compareValue("resetOut", resetOut, expectedResetOut);
    endtask

    // Outputs settle after the rising edge and are read on the falling one
    task automatic waitEdge();
        @(posedge clock);
        @(negedge clock);
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        testCount++;
        if (errorCount == errorsBefore) begin
            $display("%s: passed", name);
        end else begin
            failedTests++;
            $display("%s: %0d mismatches", name, errorCount - errorsBefore);
        end
    endtask

    `include "controlUnitTests.svh"

    initial begin
        seedResult = $urandom(74977);
        reset      = 1'b0;
        opcode     = '0;
        funct      = '0;
        multDone   = 1'b0;

        resetSequence();
        arithmetic();
        branchesAndMoves();
        multiply();
        unknownCodes();
        resetTrap();

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d mismatches",
                 testCount, failedTests, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #(2 * budgetCycles * clockPeriod);
        $display("Run timed out after %0d cycles", 2 * budgetCycles);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire
